// File: rtl/com_pkt_pkg.sv
`default_nettype none

package com_pkt_pkg;

    // ----------------------------------------
    // link identifiers
    // ----------------------------------------
    typedef enum logic [7:0] {
        PID_SYNC = 8'h01,
        PID_CMD  = 8'h1E,
        PID_ACK  = 8'h2D,
        PID_NAK  = 8'hA5,
        PID_STL  = 8'hE1
    } pid_e;

    // result reported with rx_done
    typedef enum logic [3:0] {
        PKT_NONE     = 4'h0,
        PKT_ACK      = 4'h1,
        PKT_NAK      = 4'h2,
        PKT_STL      = 4'h3,
        PKT_DEV_IDX  = 4'h5,
        PKT_DPARAM   = 4'h6,
        PKT_DATA_IDX = 4'h7,
        PKT_ERROR    = 4'hF
    } pkt_type_e;

    // upper nibble of the first payload byte
    typedef enum logic [3:0] {
        HEAD_DATA_IDX = 4'h1,
        HEAD_DPARAM   = 4'h5,
        HEAD_DEV_IDX  = 4'h9
    } head_e;

    typedef enum logic [2:0] {
        ST_HUNT,
        ST_PID,
        ST_LEN,
        ST_DATA,
        ST_CRC,
        ST_ERR,
        ST_DONE
    } rx_state_e;

    // at most one strobe set per byte
    typedef struct packed {
        logic clr;
        logic len_phase;
        logic data_phase;
        logic crc_phase;
    } rx_phase_t;

endpackage

`default_nettype wire

// File: rtl/com_mem_pkg.sv
`default_nettype none

package com_mem_pkg;

    // ----------------------------------------
    // parameter RAM map
    // ----------------------------------------
    localparam logic [7:0] BASE_DEV_IDX  = 8'h10;
    localparam logic [7:0] BASE_DATA_IDX = 8'h20;
    localparam logic [7:0] BASE_DPARAM   = 8'h80;

    // single write port towards the RAM
    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        logic [7:0] data;
    } ram_wr_t;

endpackage

`default_nettype wire

// File: rtl/rx_fsm.sv
`default_nettype none

module rx_fsm import com_pkt_pkg::*; #(
    parameter int MAX_LEN = 64,
    parameter int LEN_W   = 16
) (
    input  wire             clk,
    input  wire             rst,
    input  wire [7:0]       rxd,
    input  wire             done_ack,
    input  wire             cnt_len_last,
    input  wire             cnt_data_last,
    input  wire             len_bad,
    input  wire             crc_ok,
    input  wire             head_bad,
    input  wire pkt_type_e  head_type,
    output rx_phase_t       phase,
    output logic            rx_done,
    output pkt_type_e       pkt_type
);

    rx_state_e state;
    rx_state_e next_state;

    // the length field must be able to carry MAX_LEN
    if (MAX_LEN < 1 || MAX_LEN > (2 ** LEN_W) - 1) begin : g_len_range
        $error("rx_fsm: MAX_LEN does not fit in LEN_W bits");
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_HUNT;
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------
    // next state and phase strobes
    // ----------------------------------------
    always_comb begin
        next_state = state;
        phase      = '0;
        case (state)
            ST_HUNT: begin
                phase.clr = 1'b1;
                if (rxd == PID_SYNC) begin
                    next_state = ST_PID;
                end
            end
            ST_PID: begin
                case (rxd)
                    PID_CMD: next_state = ST_LEN;
                    PID_ACK, PID_NAK, PID_STL: next_state = ST_DONE;
                    default: next_state = ST_ERR;
                endcase
            end
            ST_LEN: begin
                phase.len_phase = 1'b1;
                if (cnt_len_last) begin
                    next_state = len_bad ? ST_ERR : ST_DATA;
                end
            end
            ST_DATA: begin
                phase.data_phase = 1'b1;
                if (cnt_data_last) begin
                    next_state = ST_CRC;
                end
            end
            ST_CRC: begin
                phase.crc_phase = 1'b1;
                next_state = (crc_ok && !head_bad) ? ST_DONE : ST_ERR;
            end
            ST_ERR:  next_state = ST_DONE;
            ST_DONE: begin
                if (done_ack) begin
                    next_state = ST_HUNT;
                end
            end
            default: next_state = ST_HUNT;
        endcase
    end

    // ----------------------------------------
    // packet result
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pkt_type <= PKT_NONE;
        end else begin
            case (state)
                ST_HUNT: pkt_type <= PKT_NONE;
                ST_PID: begin
                    case (rxd)
                        PID_ACK: pkt_type <= PKT_ACK;
                        PID_NAK: pkt_type <= PKT_NAK;
                        PID_STL: pkt_type <= PKT_STL;
                        default: pkt_type <= pkt_type;
                    endcase
                end
                ST_CRC: begin
                    if (crc_ok && !head_bad) begin
                        pkt_type <= head_type;  // region decoded by ram_writer
                    end
                end
                ST_ERR:  pkt_type <= PKT_ERROR;
                ST_DONE: begin
                    if (done_ack) begin
                        pkt_type <= PKT_NONE;
                    end
                end
                default: pkt_type <= pkt_type;
            endcase
        end
    end

    assign rx_done = (state == ST_DONE);  // held until done_ack

endmodule

`default_nettype wire

// File: rtl/rx_counter.sv
`default_nettype none

module rx_counter import com_pkt_pkg::*; #(
    parameter int MAX_LEN = 64,
    parameter int LEN_W   = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire rx_phase_t   phase,
    input  wire [LEN_W-1:0]  pkt_len,
    output logic [LEN_W-1:0] cnt,
    output logic             len_last,
    output logic             data_last
);

    localparam logic [LEN_W-1:0] CNT_MAX = LEN_W'(MAX_LEN - 1);

    // next phase starts from zero after a terminal byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (phase.clr || len_last || data_last) begin
            cnt <= '0;
        end else if (phase.len_phase || phase.data_phase) begin
            cnt <= cnt + 1'b1;
        end
    end

    // low length byte
    assign len_last = phase.len_phase && (cnt == LEN_W'(1));

    // CNT_MAX bounds the payload phase in any case
    assign data_last = phase.data_phase &&
                       ((cnt == pkt_len - 1'b1) || (cnt == CNT_MAX));

endmodule

`default_nettype wire

// File: rtl/crc5_check.sv
`default_nettype none

module crc5_check import com_pkt_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire rx_phase_t phase,
    input  wire [7:0]      rxd,
    output logic           crc_ok
);

    localparam logic [4:0] CRC_INIT = 5'h1F;
    localparam logic [4:0] CRC_POLY = 5'b00101;  // x^5 + x^2 + 1

    logic [4:0] rem;

    // eight steps msb first
    function automatic logic [4:0] crc5_byte(input logic [4:0] crc_in, input logic [7:0] data);
        logic [4:0] crc;
        logic       fb;
        crc = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb  = crc[4] ^ data[i];
            crc = {crc[3:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
        return crc;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem <= CRC_INIT;
        end else if (phase.clr) begin
            rem <= CRC_INIT;
        end else if (phase.data_phase) begin
            rem <= crc5_byte(rem, rxd);
        end
    end

    // top three bits of the crc byte are reserved zero
    assign crc_ok = phase.crc_phase && (rxd[7:5] == 3'b000) && (rxd[4:0] == rem);

endmodule

`default_nettype wire

// File: rtl/ram_writer.sv
`default_nettype none

module ram_writer import com_pkt_pkg::*, com_mem_pkg::*; #(
    parameter int MAX_LEN = 64,
    parameter int LEN_W   = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire rx_phase_t   phase,
    input  wire [7:0]        rxd,
    input  wire [LEN_W-1:0]  cnt,
    output logic [LEN_W-1:0] pkt_len,
    output logic             len_bad,
    output logic             head_bad,
    output pkt_type_e        head_type,
    output ram_wr_t          ram_wr
);

    localparam logic [15:0] LEN_LIMIT = 16'(MAX_LEN);

    logic [7:0]  len_hi;
    logic [15:0] len_q;
    logic [15:0] len_cand;
    logic        head_ok;
    logic [7:0]  head_base;
    pkt_type_e   head_dec;
    logic [7:0]  base_q;
    logic        first;
    logic        wr_ok;
    logic        wr_en_q;
    logic [7:0]  wr_addr_q;
    logic [7:0]  wr_data_q;

    // ----------------------------------------
    // length field
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (phase.len_phase && cnt == '0) begin
            len_hi <= rxd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            len_q <= '0;
        end else if (phase.clr) begin
            len_q <= '0;
        end else if (phase.len_phase && cnt != '0) begin
            len_q <= {len_hi, rxd};
        end
    end

    // low byte still on rxd during its own cycle
    assign len_cand = (phase.len_phase && cnt != '0) ? {len_hi, rxd} : len_q;
    assign len_bad  = (len_cand == '0) || (len_cand > LEN_LIMIT);
    assign pkt_len  = LEN_W'(len_q);

    // ----------------------------------------
    // header decode
    // ----------------------------------------
    always_comb begin
        head_ok   = 1'b1;
        head_base = BASE_DEV_IDX;
        head_dec  = PKT_DEV_IDX;
        case (head_e'(rxd[7:4]))
            HEAD_DEV_IDX: head_ok = 1'b1;
            HEAD_DATA_IDX: begin
                head_base = BASE_DATA_IDX;
                head_dec  = PKT_DATA_IDX;
            end
            HEAD_DPARAM: begin
                head_base = BASE_DPARAM;
                head_dec  = PKT_DPARAM;
            end
            default: begin
                head_ok  = 1'b0;
                head_dec = PKT_ERROR;
            end
        endcase
    end

    assign first = phase.data_phase && (cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_bad  <= 1'b0;
            head_type <= PKT_NONE;
        end else if (phase.clr) begin
            head_bad  <= 1'b0;
            head_type <= PKT_NONE;
        end else if (first) begin
            head_bad  <= !head_ok;
            head_type <= head_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (first) begin
            base_q <= head_base;
        end
    end

    // ----------------------------------------
    // registered write port
    // ----------------------------------------
    assign wr_ok = first ? head_ok : !head_bad;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= phase.data_phase && wr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (phase.data_phase) begin
            wr_addr_q <= (first ? head_base : base_q) + cnt[7:0];  // header at base
            wr_data_q <= rxd;
        end
    end

    assign ram_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

`default_nettype wire

// File: rtl/com_rx_top.sv
`default_nettype none

module com_rx_top import com_pkt_pkg::*, com_mem_pkg::*; #(
    parameter int MAX_LEN = 64,
    parameter int LEN_W   = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [7:0]        rxd,
    input  wire              done_ack,
    output logic             rx_done,
    output pkt_type_e        pkt_type,
    output logic [LEN_W-1:0] pkt_len,
    output ram_wr_t          ram_wr
);

    rx_phase_t        phase;
    logic [LEN_W-1:0] cnt;
    logic             len_last;
    logic             data_last;
    logic             len_bad;
    logic             head_bad;
    pkt_type_e        head_type;
    logic             crc_ok;

    rx_fsm #(
        .MAX_LEN (MAX_LEN),
        .LEN_W   (LEN_W)
    ) u_fsm (
        .clk           (clk),
        .rst           (rst),
        .rxd           (rxd),
        .done_ack      (done_ack),
        .cnt_len_last  (len_last),
        .cnt_data_last (data_last),
        .len_bad       (len_bad),
        .crc_ok        (crc_ok),
        .head_bad      (head_bad),
        .head_type     (head_type),
        .phase         (phase),
        .rx_done       (rx_done),
        .pkt_type      (pkt_type)
    );

    rx_counter #(
        .MAX_LEN (MAX_LEN),
        .LEN_W   (LEN_W)
    ) u_counter (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .pkt_len   (pkt_len),
        .cnt       (cnt),
        .len_last  (len_last),
        .data_last (data_last)
    );

    crc5_check u_crc (
        .clk    (clk),
        .rst    (rst),
        .phase  (phase),
        .rxd    (rxd),
        .crc_ok (crc_ok)
    );

    ram_writer #(
        .MAX_LEN (MAX_LEN),
        .LEN_W   (LEN_W)
    ) u_writer (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .rxd       (rxd),
        .cnt       (cnt),
        .pkt_len   (pkt_len),
        .len_bad   (len_bad),
        .head_bad  (head_bad),
        .head_type (head_type),
        .ram_wr    (ram_wr)
    );

endmodule

`default_nettype wire

// File: tb/com_rx_assert.sv
`default_nettype none

module com_rx_assert import com_pkt_pkg::*, com_mem_pkg::*; (
    input wire            clk,
    input wire            rst,
    input wire            rx_done,
    input wire pkt_type_e pkt_type,
    input wire ram_wr_t   ram_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    int reset_fails;
    int busy_fails;
    int stable_fails;
    int fail_count;

    assign fail_count = reset_fails + busy_fails + stable_fails;

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !rx_done && !ram_wr.en && pkt_type == PKT_NONE)
        else begin
            $error("outputs not idle when reset is released");
            reset_fails++;
        end

    a_no_write_done: assert property (@(posedge clk) disable iff (rst)
        rx_done |-> !ram_wr.en)
        else begin
            $error("RAM write strobe while rx_done is high");
            busy_fails++;
        end

    // result held for the host
    a_type_stable: assert property (@(posedge clk) disable iff (rst)
        $past(rx_done) && rx_done |-> $stable(pkt_type))
        else begin
            $error("pkt_type changed while rx_done is high");
            stable_fails++;
        end

endmodule

bind com_rx_top com_rx_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .rx_done  (rx_done),
    .pkt_type (pkt_type),
    .ram_wr   (ram_wr)
);

`default_nettype wire

// File: tb/com_rx_checker.sv
`default_nettype none

module com_rx_checker import com_pkt_pkg::*, com_mem_pkg::*; #(
    parameter int LEN_W = 16
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             done_ack,
    input  wire             rx_done,
    input  wire pkt_type_e  pkt_type,
    input  wire [LEN_W-1:0] pkt_len,
    input  wire ram_wr_t    ram_wr,
    output int              tests_run,
    output int              tests_failed,
    output int              err_total
);
    timeunit 1ns;
    timeprecision 1ps;

    // expectations of the running test
    string            test_name;
    pkt_type_e        exp_type;
    logic [LEN_W-1:0] exp_len;
    logic [7:0]       exp_addr [$];
    logic [7:0]       exp_data [$];
    int               wr_base;
    int               done_base;
    int               fall_base;

    // everything seen on the DUT outputs
    logic [7:0]       obs_addr [$];
    logic [7:0]       obs_data [$];
    logic             obs_held [$];
    pkt_type_e        obs_type [$];
    logic [LEN_W-1:0] obs_len  [$];
    logic             done_q;
    logic             ack_q;
    int               early_falls;

    // done_ack as the DUT saw it on the rising edge
    always @(posedge clk) begin
        ack_q <= done_ack;
    end

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (ram_wr.en) begin
                obs_addr.push_back(ram_wr.addr);
                obs_data.push_back(ram_wr.data);
                obs_held.push_back(rx_done);
            end
            if (rx_done && !done_q) begin
                obs_type.push_back(pkt_type);
                obs_len.push_back(pkt_len);
            end
            if (done_q && !rx_done && !ack_q) begin
                early_falls++;
            end
        end
        done_q <= rx_done;
    end

    task automatic start_test(input string name, input pkt_type_e typ,
                              input logic [LEN_W-1:0] len);
        test_name = name;
        exp_type  = typ;
        exp_len   = len;
        exp_addr.delete();
        exp_data.delete();
        wr_base   = obs_addr.size();
        done_base = obs_type.size();
        fall_base = early_falls;
    endtask

    task automatic expect_write(input logic [7:0] addr, input logic [7:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // ----------------------------------------
    // compare at the end of a test
    // ----------------------------------------
    task automatic end_test();
        int errs;
        int n_wr;
        int n_done;
        int n_fall;
        int k;
        errs   = 0;
        n_wr   = obs_addr.size() - wr_base;
        n_done = obs_type.size() - done_base;
        n_fall = early_falls - fall_base;
        if (n_done != 1) begin
            $display("%s: rx_done rose %0d times instead of once", test_name, n_done);
            errs++;
        end else begin
            if (obs_type[done_base] != exp_type) begin
                $display("FAILED %s pkt_type: expected %h, actual %h", test_name, exp_type,
                         obs_type[done_base]);
                errs++;
            end
            if (obs_len[done_base] != exp_len) begin
                $display("FAILED %s pkt_len: expected %0d, actual %0d", test_name, exp_len,
                         obs_len[done_base]);
                errs++;
            end
        end
        if (n_fall != 0) begin
            $display("%s: rx_done fell %0d times before done_ack", test_name, n_fall);
            errs++;
        end
        if (n_wr != exp_addr.size()) begin
            $display("FAILED %s write count: expected %0d, actual %0d", test_name,
                     exp_addr.size(), n_wr);
            errs++;
        end
        for (int i = 0; i < n_wr; i++) begin
            k = wr_base + i;
            if (obs_held[k]) begin
                $display("%s: RAM write to %h while rx_done was high", test_name, obs_addr[k]);
                errs++;
            end
            if (i < exp_addr.size()) begin
                if (obs_addr[k] != exp_addr[i]) begin
                    $display("FAILED %s write %0d addr: expected %h, actual %h", test_name, i,
                             exp_addr[i], obs_addr[k]);
                    errs++;
                end
                if (obs_data[k] != exp_data[i]) begin
                    $display("FAILED %s write %0d data: expected %h, actual %h", test_name, i,
                             exp_data[i], obs_data[k]);
                    errs++;
                end
            end
        end
        tests_run++;
        err_total += errs;
        if (errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errs);
        end else begin
            $display("test %s: ok, %0d writes", test_name, n_wr);
        end
    endtask

endmodule

`default_nettype wire

// File: tb/tb_com_rx.sv
`default_nettype none

module tb_com_rx import com_pkt_pkg::*, com_mem_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_LEN    = 64;
    localparam int          LEN_W      = 16;
    localparam int          WAIT_LIMIT = 100;
    localparam logic [31:0] SEED       = 32'h3b7a0577;
    localparam string       STIM_FILE  = "tb/com_rx_stimulus.txt";

    // sent while rx_done is high and ignored by the DUT
    localparam logic [7:0] HOLD_BYTES [5] = '{8'h01, 8'h1E, 8'h00, 8'h02, 8'h1A};

    logic             clk;
    logic             rst;
    logic [7:0]       rxd;
    logic             done_ack;
    logic             rx_done;
    pkt_type_e        pkt_type;
    logic [LEN_W-1:0] pkt_len;
    ram_wr_t          ram_wr;
    int               tests_run;
    int               tests_failed;
    int               check_errs;
    bit               timed_out;

    com_rx_top #(
        .MAX_LEN (MAX_LEN),
        .LEN_W   (LEN_W)
    ) u_com_rx_top (
        .clk      (clk),
        .rst      (rst),
        .rxd      (rxd),
        .done_ack (done_ack),
        .rx_done  (rx_done),
        .pkt_type (pkt_type),
        .pkt_len  (pkt_len),
        .ram_wr   (ram_wr)
    );

    com_rx_checker #(
        .LEN_W (LEN_W)
    ) u_check (
        .clk          (clk),
        .rst          (rst),
        .done_ack     (done_ack),
        .rx_done      (rx_done),
        .pkt_type     (pkt_type),
        .pkt_len      (pkt_len),
        .ram_wr       (ram_wr),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .err_total    (check_errs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------
    // packet helpers
    // ----------------------------------------
    function automatic logic [4:0] crc5_step(input logic [4:0] c, input logic [7:0] d);
        logic [4:0] r;
        logic       fb;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            fb = r[4] ^ d[i];
            r  = {r[3], r[2], r[1] ^ fb, r[0], fb};  // taps of x^5 + x^2 + 1
        end
        return r;
    endfunction

    function automatic bit region_of(input logic [3:0] head, output logic [7:0] base);
        base = 8'h00;
        case (head)
            HEAD_DEV_IDX:  base = BASE_DEV_IDX;
            HEAD_DATA_IDX: base = BASE_DATA_IDX;
            HEAD_DPARAM:   base = BASE_DPARAM;
            default:       return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic [7:0] junk_byte();
        logic [7:0] b;
        b = 8'($urandom);
        while (b == PID_SYNC) begin
            b = 8'($urandom);
        end
        return b;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rxd = b;
    endtask

    task automatic wait_done(input logic level, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            ok = (rx_done == level);
            n++;
        end
    endtask

    task automatic run_test(input string name, input string kind, input logic [7:0] pid,
                            input logic [3:0] head, input int len, input bit bad_crc,
                            input pkt_type_e exp_type);
        logic [7:0] bytes [$];
        logic [7:0] base;
        logic [7:0] b;
        logic [4:0] crc;
        bit         known;
        bit         writes;
        bit         ok;
        known  = region_of(head, base);
        writes = known && kind != "hs" && len >= 1 && len <= MAX_LEN;
        u_check.start_test(name, exp_type, (kind == "hs") ? '0 : LEN_W'(len));
        crc = 5'h1F;
        if (kind == "skip") begin
            repeat (3) bytes.push_back(junk_byte());
        end
        bytes.push_back(PID_SYNC);
        bytes.push_back(pid);
        if (kind != "hs") begin
            bytes.push_back(8'(len >> 8));
            bytes.push_back(8'(len));
            for (int i = 0; i < len; i++) begin
                b   = (i == 0) ? {head, 4'($urandom)} : 8'($urandom);
                crc = crc5_step(crc, b);
                bytes.push_back(b);
                if (writes) begin
                    u_check.expect_write(base + 8'(i), b);
                end
            end
            bytes.push_back({3'b000, crc ^ {4'b0000, bad_crc}});
        end
        foreach (bytes[i]) send_byte(bytes[i]);
        wait_done(1'b1, ok);
        if (!ok) begin
            $display("timeout: rx_done did not rise in test %s", name);
        end else begin
            for (int i = 0; i < 5; i++) begin
                send_byte(HOLD_BYTES[i]);
            end
            @(negedge clk);
            rxd      = 8'h00;
            done_ack = 1'b1;
            wait_done(1'b0, ok);
            done_ack = 1'b0;
            if (!ok) begin
                $display("timeout: rx_done stayed high after done_ack in test %s", name);
            end
        end
        if (!ok) begin
            timed_out = 1'b1;
        end
        u_check.end_test();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int         fd;
        int         n;
        int         len;
        int         bad;
        int         assert_fails;
        bit         file_err;
        string      line;
        string      name;
        string      kind;
        logic [7:0] pid;
        logic [3:0] head;
        logic [3:0] exp_code;
        void'($urandom(SEED));
        rst       = 1'b1;
        rxd       = 8'h00;
        done_ack  = 1'b0;
        timed_out = 1'b0;
        file_err  = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            file_err = 1'b1;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %s %h %h %d %d %h", name, kind, pid, head, len, bad,
                            exp_code);
                if (n == 7 && line.getc(0) != "#") begin
                    run_test(name, kind, pid, head, len, bad != 0, pkt_type_e'(exp_code));
                end
            end
            $fclose(fd);
        end

        assert_fails = u_com_rx_top.u_assert.fail_count;
        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_errs, assert_fails);
        if (!timed_out && !file_err && tests_run > 0 && tests_failed == 0 &&
            check_errs == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/com_rx_stimulus.txt
# name kind pid(hex) head(hex) len(dec) bad_crc exp_type(hex)
# kind: hs = sync and pid only, cmd = command packet, skip = junk bytes then command packet
hs_ack      hs   2D 0 0   0 1
hs_nak      hs   A5 0 0   0 2
hs_stl      hs   E1 0 0   0 3
cmd_dev     cmd  1E 9 8   0 5
cmd_data    cmd  1E 1 1   0 7
cmd_dparam  cmd  1E 5 64  0 6
crc_bad     cmd  1E 1 12  1 F
pid_bad     hs   3C 0 0   0 F
head_bad    cmd  1E 3 6   0 F
len_big     cmd  1E 9 300 0 F
len_zero    cmd  1E 9 0   0 F
skip_junk   skip 1E 5 5   0 6
cmd_data_2  cmd  1E 1 17  0 7
cmd_dev_2   cmd  1E 9 33  0 5

// File: src.f
rtl/com_pkt_pkg.sv
rtl/com_mem_pkg.sv
rtl/rx_fsm.sv
rtl/rx_counter.sv
rtl/crc5_check.sv
rtl/ram_writer.sv
rtl/com_rx_top.sv
tb/com_rx_assert.sv
tb/com_rx_checker.sv
tb/tb_com_rx.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_com_rx
FILELIST  := src.f
SIM_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
